// ==== logic/pipe_pkg.sv ====
// rv32i subset only (no loads/stores); 64-bit memory block carries two instructions; tag 0 = none
package pipe_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and constants
    //////////////////////////////////////////////////////////////////////

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int mem_tag_w = 4;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [mem_tag_w-1:0] mem_tag_t;
    typedef logic [63:0]          mem_block_t;

    // addi x0, x0, 0
    localparam word_t inst_nop = 32'h0000_0013;

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    // only instruction fetches on this bus
    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_command_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B,
        ALU_BEQ,
        ALU_BNE,
        ALU_JAL
    } alu_op_t;

    typedef enum logic [1:0] {
        NO_ERROR      = 2'h0,
        HALTED_ON_WFI = 2'h1
    } exception_code_t;

    //////////////////////////////////////////////////////////////////////
    // stage packets
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t inst;
        word_t pc;
        word_t npc;
    } if_id_packet_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        // pc+4, filled in by fetch
        word_t    npc;
        alu_op_t  op;
        // unused sources are forced to x0
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        reg_idx_t dest_idx;
        logic     wr_en;
        word_t    imm;
        logic     uses_imm;
        logic     halt;
    } id_is_packet_t;

    // decoded fields plus operands read at issue
    typedef struct packed {
        id_is_packet_t id;
        word_t         rs1_value;
        word_t         rs2_value;
    } is_ex_packet_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest_idx;
        logic     wr_en;
        word_t    result;
        word_t    npc;
        logic     take_branch;
        logic     halt;
    } ex_co_packet_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest_idx;
        logic     wr_en;
        word_t    result;
        word_t    npc;
        logic     halt;
    } co_re_packet_t;

endpackage

// ==== logic/fetch_unit.sv ====
// one request outstanding at a time, one-entry buffer; memory must echo the accepted tag on reply
`timescale 1ns/1ps

module fetch_unit #(
    parameter pipe_pkg::word_t reset_pc = '0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    halted,
    input  logic                    stall,
    input  logic                    redirect,
    input  pipe_pkg::word_t         redirect_pc,
    input  pipe_pkg::mem_tag_t      mem2proc_response,
    input  pipe_pkg::mem_tag_t      mem2proc_tag,
    input  pipe_pkg::mem_block_t    mem2proc_data,
    output pipe_pkg::bus_command_t  proc2mem_command,
    output pipe_pkg::word_t         proc2mem_addr,
    output pipe_pkg::if_id_packet_t if_packet
);
    import pipe_pkg::*;

    // pc is the address being fetched or held in the buffer
    word_t    pc;
    mem_tag_t pending_tag;
    // reply of a request made before a redirect
    logic     stale;
    // keeps the bus idle for the first cycle out of reset
    logic     started;
    logic     buf_valid;
    word_t    buf_inst;

    logic     request;
    logic     reply_hit;
    logic     consume;

    // no new request while a tag is out or the buffer is full
    assign request = started && !halted && !redirect && (pending_tag == '0) && !buf_valid;
    assign proc2mem_command = request ? BUS_LOAD : BUS_NONE;
    // block aligned, pc[2] picks the half later
    assign proc2mem_addr = {pc[xlen-1:3], 3'b000};

    assign reply_hit = (pending_tag != '0) && (mem2proc_tag == pending_tag);
    assign consume   = buf_valid && !stall;

    always_comb begin
        if_packet.valid = buf_valid;
        if_packet.inst  = buf_inst;
        if_packet.pc    = pc;
        if_packet.npc   = pc + 32'd4;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= reset_pc;
            pending_tag <= '0;
            stale       <= 1'b0;
            started     <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            started <= 1'b1;

            // tag tracking, zero response means rejected, retry next cycle
            if (request && (mem2proc_response != '0)) begin
                pending_tag <= mem2proc_response;
            end else if (reply_hit) begin
                pending_tag <= '0;
            end

            if (reply_hit) begin
                stale <= 1'b0;
            end else if (redirect && (pending_tag != '0)) begin
                stale <= 1'b1;
            end

            // redirect wins over fill and consume
            if (redirect) begin
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
            end else if (reply_hit && !stale) begin
                buf_valid <= 1'b1;
            end else if (consume) begin
                buf_valid <= 1'b0;
                pc        <= pc + 32'd4;
            end
        end
    end

    // instruction payload
    always_ff @(posedge clock) begin
        if (reply_hit) begin
            buf_inst <= pc[2] ? mem2proc_data[63:32] : mem2proc_data[31:0];
        end
    end

    // accepted request leaves the bus idle next cycle
    assert property (@(posedge clock) disable iff (reset)
        (proc2mem_command == BUS_LOAD) && (mem2proc_response != '0)
        |=> (proc2mem_command == BUS_NONE));

endmodule

// ==== logic/decode_unit.sv ====
// unsupported encodings decode as no-ops that still commit; stall covers all three younger stages
`timescale 1ns/1ps

module decode_unit (
    input  pipe_pkg::if_id_packet_t       if_packet,
    input  pipe_pkg::id_is_packet_t [2:0] hazard_pkts,
    output pipe_pkg::id_is_packet_t       id_packet,
    output logic                          stall
);
    import pipe_pkg::*;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    localparam word_t inst_wfi = 32'h1050_0073;

    opcode_t  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm_i;
    word_t    imm_u;
    word_t    imm_b;
    word_t    imm_j;

    alu_op_t  op;
    word_t    imm;
    logic     uses_imm;
    logic     reads_rs1;
    logic     reads_rs2;
    logic     writes;
    logic     halt;
    logic     hazard;

    // raw fields
    assign opcode = opcode_t'(if_packet.inst[6:0]);
    assign funct3 = if_packet.inst[14:12];
    assign funct7 = if_packet.inst[31:25];
    assign rs1    = if_packet.inst[19:15];
    assign rs2    = if_packet.inst[24:20];
    assign rd     = if_packet.inst[11:7];

    // sign-extended immediates
    assign imm_i = {{20{if_packet.inst[31]}}, if_packet.inst[31:20]};
    assign imm_u = {if_packet.inst[31:12], 12'b0};
    assign imm_b = {{19{if_packet.inst[31]}}, if_packet.inst[31], if_packet.inst[7],
                    if_packet.inst[30:25], if_packet.inst[11:8], 1'b0};
    assign imm_j = {{11{if_packet.inst[31]}}, if_packet.inst[31], if_packet.inst[19:12],
                    if_packet.inst[20], if_packet.inst[30:21], 1'b0};

    always_comb begin
        op        = ALU_ADD;
        imm       = '0;
        uses_imm  = 1'b0;
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        writes    = 1'b0;
        halt      = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    imm       = imm_i;
                    uses_imm  = 1'b1;
                    reads_rs1 = 1'b1;
                    writes    = 1'b1;
                end
            end
            OPC_OP: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                writes    = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op = ALU_ADD;
                    {7'h20, 3'b000}: op = ALU_SUB;
                    {7'h00, 3'b111}: op = ALU_AND;
                    {7'h00, 3'b110}: op = ALU_OR;
                    {7'h00, 3'b100}: op = ALU_XOR;
                    {7'h00, 3'b010}: op = ALU_SLT;
                    default: begin
                        reads_rs1 = 1'b0;
                        reads_rs2 = 1'b0;
                        writes    = 1'b0;
                    end
                endcase
            end
            OPC_LUI: begin
                op       = ALU_PASS_B;
                imm      = imm_u;
                uses_imm = 1'b1;
                writes   = 1'b1;
            end
            OPC_BRANCH: begin
                // beq and bne, funct3 bit 0 tells them apart
                if (funct3[2:1] == 2'b00) begin
                    op        = funct3[0] ? ALU_BNE : ALU_BEQ;
                    imm       = imm_b;
                    reads_rs1 = 1'b1;
                    reads_rs2 = 1'b1;
                end
            end
            OPC_JAL: begin
                op     = ALU_JAL;
                imm    = imm_j;
                writes = 1'b1;
            end
            OPC_SYSTEM: begin
                halt = (if_packet.inst == inst_wfi);
            end
            default: begin
                op = ALU_ADD;
            end
        endcase
    end

    // match against in-flight destinations, x0 never matches
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (hazard_pkts[i].valid && hazard_pkts[i].wr_en &&
                (hazard_pkts[i].dest_idx != '0) &&
                ((reads_rs1 && (hazard_pkts[i].dest_idx == rs1)) ||
                 (reads_rs2 && (hazard_pkts[i].dest_idx == rs2)))) begin
                hazard = 1'b1;
            end
        end
    end

    assign stall = if_packet.valid && hazard;

    always_comb begin
        // bubble while stalled
        id_packet.valid    = if_packet.valid && !stall;
        id_packet.pc       = if_packet.pc;
        id_packet.npc      = if_packet.npc;
        id_packet.op       = op;
        id_packet.rs1_idx  = reads_rs1 ? rs1 : '0;
        id_packet.rs2_idx  = reads_rs2 ? rs2 : '0;
        id_packet.dest_idx = writes ? rd : '0;
        id_packet.wr_en    = writes && (rd != '0);
        id_packet.imm      = imm;
        id_packet.uses_imm = uses_imm;
        id_packet.halt     = halt;
    end

endmodule

// ==== logic/regfile.sv ====
// no reset, contents unknown until written; x0 reads zero; write forwards to same-cycle reads
`timescale 1ns/1ps

module regfile (
    input  logic               clock,
    input  pipe_pkg::reg_idx_t read_idx_1,
    input  pipe_pkg::reg_idx_t read_idx_2,
    input  logic               write_en,
    input  pipe_pkg::reg_idx_t write_idx,
    input  pipe_pkg::word_t    write_data,
    output pipe_pkg::word_t    read_out_1,
    output pipe_pkg::word_t    read_out_2
);
    import pipe_pkg::*;

    word_t regs [32];

    // write-through from the complete stage
    always_comb begin
        if (read_idx_1 == '0) begin
            read_out_1 = '0;
        end else if (write_en && (write_idx == read_idx_1)) begin
            read_out_1 = write_data;
        end else begin
            read_out_1 = regs[read_idx_1];
        end
    end

    always_comb begin
        if (read_idx_2 == '0) begin
            read_out_2 = '0;
        end else if (write_en && (write_idx == read_idx_2)) begin
            read_out_2 = write_data;
        end else begin
            read_out_2 = regs[read_idx_2];
        end
    end

    always_ff @(posedge clock) begin
        if (write_en && (write_idx != '0)) begin
            regs[write_idx] <= write_data;
        end
    end

    // decode clears wr_en for rd = x0
    assert property (@(posedge clock) write_en |-> (write_idx != '0));

endmodule

// ==== logic/execute_unit.sv ====
// single-cycle ALU; branch target is pc + imm, fall-through taken from the packet npc
`timescale 1ns/1ps

module execute_unit (
    input  pipe_pkg::is_ex_packet_t is_ex,
    output pipe_pkg::ex_co_packet_t ex_packet
);
    import pipe_pkg::*;

    word_t opa;
    word_t opb;
    word_t result;
    word_t target;
    logic  take;

    assign opa    = is_ex.rs1_value;
    assign opb    = is_ex.id.uses_imm ? is_ex.id.imm : is_ex.rs2_value;
    assign target = is_ex.id.pc + is_ex.id.imm;

    always_comb begin
        result = '0;
        take   = 1'b0;
        case (is_ex.id.op)
            ALU_ADD:    result = opa + opb;
            ALU_SUB:    result = opa - opb;
            ALU_AND:    result = opa & opb;
            ALU_OR:     result = opa | opb;
            ALU_XOR:    result = opa ^ opb;
            ALU_SLT:    result = word_t'($signed(opa) < $signed(opb));
            // lui
            ALU_PASS_B: result = opb;
            ALU_BEQ:    take = (opa == opb);
            ALU_BNE:    take = (opa != opb);
            ALU_JAL: begin
                // link value is pc+4
                result = is_ex.id.npc;
                take   = 1'b1;
            end
            default:    result = '0;
        endcase
    end

    always_comb begin
        ex_packet.valid       = is_ex.id.valid;
        ex_packet.dest_idx    = is_ex.id.dest_idx;
        ex_packet.wr_en       = is_ex.id.wr_en;
        ex_packet.result      = result;
        ex_packet.npc         = take ? target : is_ex.id.npc;
        ex_packet.take_branch = take;
        ex_packet.halt        = is_ex.id.halt;
    end

endmodule

// ==== logic/retire_unit.sv ====
// halt is sticky until reset; packets reaching retire after wfi are dropped without commit
`timescale 1ns/1ps

module retire_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  pipe_pkg::co_re_packet_t   co_re,
    output logic                      halted,
    output logic                      commit_valid,
    output logic                      commit_wr_en,
    output pipe_pkg::reg_idx_t        commit_wr_idx,
    output pipe_pkg::word_t           commit_wr_data,
    output pipe_pkg::word_t           commit_npc,
    output pipe_pkg::exception_code_t error_status
);
    import pipe_pkg::*;

    logic do_commit;

    assign halted    = (error_status == HALTED_ON_WFI);
    assign do_commit = co_re.valid && !halted;

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid   <= 1'b0;
            commit_wr_en   <= 1'b0;
            commit_wr_idx  <= '0;
            commit_wr_data <= '0;
            commit_npc     <= '0;
            error_status   <= NO_ERROR;
        end else begin
            commit_valid <= do_commit;
            commit_wr_en <= do_commit && co_re.wr_en;
            if (do_commit) begin
                commit_wr_idx  <= co_re.dest_idx;
                commit_wr_data <= co_re.result;
                commit_npc     <= co_re.npc;
            end
            // wfi itself still commits
            if (do_commit && co_re.halt) begin
                error_status <= HALTED_ON_WFI;
            end
        end
    end

    // nothing commits once the halt has been seen
    assert property (@(posedge clock) disable iff (reset)
        $past(halted) |-> !commit_valid);

endmodule

// ==== logic/pipeline.sv ====
// in-order, no forwarding beyond regfile write-through; taken branches resolve in execute
`timescale 1ns/1ps

module pipeline #(
    parameter pipe_pkg::word_t reset_pc = '0
) (
    input  logic                      clock,
    input  logic                      reset,
    input  pipe_pkg::mem_tag_t        mem2proc_response,
    input  pipe_pkg::mem_tag_t        mem2proc_tag,
    input  pipe_pkg::mem_block_t      mem2proc_data,
    output pipe_pkg::bus_command_t    proc2mem_command,
    output pipe_pkg::word_t           proc2mem_addr,
    output logic                      commit_valid,
    output logic                      commit_wr_en,
    output pipe_pkg::reg_idx_t        commit_wr_idx,
    output pipe_pkg::word_t           commit_wr_data,
    output pipe_pkg::word_t           commit_npc,
    output pipe_pkg::exception_code_t error_status
);
    import pipe_pkg::*;

    localparam if_id_packet_t if_id_bubble = '{valid: 1'b0, inst: inst_nop, pc: '0, npc: '0};
    localparam id_is_packet_t id_is_bubble = '0;
    localparam is_ex_packet_t is_ex_bubble = '0;

    //////////////////////////////////////////////////////////////////////
    // stage packets and pipeline registers
    //////////////////////////////////////////////////////////////////////

    if_id_packet_t       if_packet;
    if_id_packet_t       if_id_reg;
    id_is_packet_t       id_packet;
    id_is_packet_t       id_is_reg;
    is_ex_packet_t       is_packet;
    is_ex_packet_t       is_ex_reg;
    ex_co_packet_t       ex_packet;
    ex_co_packet_t       ex_co_reg;
    co_re_packet_t       co_packet;
    co_re_packet_t       co_re_reg;

    id_is_packet_t [2:0] hazard_pkts;
    word_t               rf_read_1;
    word_t               rf_read_2;
    logic                stall;
    logic                rollback;
    logic                halted;

    // taken branch or jal in execute
    assign rollback = ex_packet.valid && ex_packet.take_branch;

    fetch_unit #(
        .reset_pc(reset_pc)
    ) fetch_i (
        .clock            (clock),
        .reset            (reset),
        .halted           (halted),
        .stall            (stall),
        .redirect         (rollback),
        .redirect_pc      (ex_packet.npc),
        .mem2proc_response(mem2proc_response),
        .mem2proc_tag     (mem2proc_tag),
        .mem2proc_data    (mem2proc_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .if_packet        (if_packet)
    );

    // destination summaries of everything younger than decode
    always_comb begin
        hazard_pkts[0]          = id_is_reg;
        hazard_pkts[1]          = is_ex_reg.id;
        hazard_pkts[2]          = id_is_bubble;
        hazard_pkts[2].valid    = ex_co_reg.valid;
        hazard_pkts[2].dest_idx = ex_co_reg.dest_idx;
        hazard_pkts[2].wr_en    = ex_co_reg.wr_en;
    end

    decode_unit decode_i (
        .if_packet  (if_id_reg),
        .hazard_pkts(hazard_pkts),
        .id_packet  (id_packet),
        .stall      (stall)
    );

    //////////////////////////////////////////////////////////////////////
    // issue reads, complete writes
    //////////////////////////////////////////////////////////////////////

    regfile regfile_i (
        .clock     (clock),
        .read_idx_1(id_is_reg.rs1_idx),
        .read_idx_2(id_is_reg.rs2_idx),
        .write_en  (ex_co_reg.valid && ex_co_reg.wr_en),
        .write_idx (ex_co_reg.dest_idx),
        .write_data(ex_co_reg.result),
        .read_out_1(rf_read_1),
        .read_out_2(rf_read_2)
    );

    always_comb begin
        is_packet.id        = id_is_reg;
        is_packet.rs1_value = rf_read_1;
        is_packet.rs2_value = rf_read_2;
    end

    execute_unit execute_i (
        .is_ex    (is_ex_reg),
        .ex_packet(ex_packet)
    );

    // take_branch is dropped on the way to retire
    always_comb begin
        co_packet.valid    = ex_co_reg.valid;
        co_packet.dest_idx = ex_co_reg.dest_idx;
        co_packet.wr_en    = ex_co_reg.wr_en;
        co_packet.result   = ex_co_reg.result;
        co_packet.npc      = ex_co_reg.npc;
        co_packet.halt     = ex_co_reg.halt;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            if_id_reg <= if_id_bubble;
            id_is_reg <= id_is_bubble;
            is_ex_reg <= is_ex_bubble;
            ex_co_reg <= '0;
            co_re_reg <= '0;
        end else begin
            // if/id holds on stall, rollback flushes it
            if (rollback) begin
                if_id_reg <= if_id_bubble;
            end else if (!stall) begin
                if_id_reg <= if_packet;
            end
            // decode already emits a bubble on stall
            if (rollback) begin
                id_is_reg <= id_is_bubble;
                is_ex_reg <= is_ex_bubble;
            end else begin
                id_is_reg <= id_packet;
                is_ex_reg <= is_packet;
            end
            // the branch itself moves on and commits
            ex_co_reg <= ex_packet;
            co_re_reg <= co_packet;
        end
    end

    retire_unit retire_i (
        .clock         (clock),
        .reset         (reset),
        .co_re         (co_re_reg),
        .halted        (halted),
        .commit_valid  (commit_valid),
        .commit_wr_en  (commit_wr_en),
        .commit_wr_idx (commit_wr_idx),
        .commit_wr_data(commit_wr_data),
        .commit_npc    (commit_npc),
        .error_status  (error_status)
    );

endmodule

// ==== sim/pipeline_tb.sv ====
// run from the project root; stops at the first mismatch; needs 17-ish cycles per fetch at worst
`timescale 1ns/1ps

module pipeline_tb;
    import pipe_pkg::*;

    localparam word_t reset_pc  = '0;
    localparam int    mem_words = 256;

    // one expected retire record
    typedef struct packed {
        logic     wr_en;
        reg_idx_t idx;
        word_t    data;
        word_t    npc;
    } commit_rec_t;

    logic            clock = 1'b0;
    logic            reset = 1'b1;
    mem_tag_t        mem2proc_response = '0;
    mem_tag_t        mem2proc_tag = '0;
    mem_block_t      mem2proc_data = '0;
    bus_command_t    proc2mem_command;
    word_t           proc2mem_addr;
    logic            commit_valid;
    logic            commit_wr_en;
    reg_idx_t        commit_wr_idx;
    word_t           commit_wr_data;
    word_t           commit_npc;
    exception_code_t error_status;

    word_t       program_mem [mem_words];
    commit_rec_t expected [$];
    commit_rec_t rec;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    int          commits_seen = 0;

    // memory model state
    logic [31:0] rng = 32'hdf107c8c;
    logic        busy = 1'b0;
    logic [1:0]  wait_cnt = '0;
    mem_tag_t    cur_tag = '0;
    word_t       cur_addr = '0;
    mem_tag_t    next_tag = 4'd1;
    logic        first_seen = 1'b0;

    pipeline #(
        .reset_pc(reset_pc)
    ) pipeline_i (
        .clock            (clock),
        .reset            (reset),
        .mem2proc_response(mem2proc_response),
        .mem2proc_tag     (mem2proc_tag),
        .mem2proc_data    (mem2proc_data),
        .proc2mem_command (proc2mem_command),
        .proc2mem_addr    (proc2mem_addr),
        .commit_valid     (commit_valid),
        .commit_wr_en     (commit_wr_en),
        .commit_wr_idx    (commit_wr_idx),
        .commit_wr_data   (commit_wr_data),
        .commit_npc       (commit_npc),
        .error_status     (error_status)
    );

    always #50 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // aligned 8-byte block, lower word at the even index
    function automatic mem_block_t read_block(input word_t addr);
        logic [7:0] base;
        base = {addr[9:3], 1'b0};
        return {program_mem[base + 8'd1], program_mem[base]};
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_commit(
        input logic     exp_wr_en,
        input reg_idx_t exp_idx,
        input word_t    exp_data,
        input word_t    exp_npc
    );
        logic bad;
        bad = (commit_wr_en !== exp_wr_en) || (commit_npc !== exp_npc);
        // idx and data only count for a register write
        if (exp_wr_en && ((commit_wr_idx !== exp_idx) || (commit_wr_data !== exp_data))) begin
            bad = 1'b1;
        end
        if (bad) begin
            stop_with_failure($sformatf(
                "FAILED at %0t: commit %0d wr %b x%0d %h npc %h, want wr %b x%0d %h npc %h",
                $time, commits_seen, commit_wr_en, commit_wr_idx, commit_wr_data, commit_npc,
                exp_wr_en, exp_idx, exp_data, exp_npc));
        end
    endtask

    task automatic check_status(input exception_code_t exp);
        if (error_status !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: error_status %0d, expected %0d",
                $time, error_status, exp));
        end
    endtask

    task automatic check_command(input bus_command_t exp);
        if (proc2mem_command !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: proc2mem_command %0d, expected %0d",
                $time, proc2mem_command, exp));
        end
    endtask

    task automatic check_fetch_addr(input word_t got);
        if (got !== reset_pc) begin
            stop_with_failure($sformatf("FAILED at %0t: first fetch address %h, expected %h",
                $time, got, reset_pc));
        end
    endtask

    task automatic check_idle();
        if (commit_valid !== 1'b0) begin
            stop_with_failure($sformatf("FAILED at %0t: commit_valid high with no commit due",
                $time));
        end
    endtask

    task automatic load_program();
        int               fd;
        int               n;
        logic [7:0]       kind;
        logic [8*160-1:0] rest;
        logic [31:0]      addr;
        logic [31:0]      word;
        int               rec_wr_en;
        int               rec_idx;
        logic [31:0]      rec_data;
        logic [31:0]      rec_npc;
        commit_rec_t      entry;
        logic             done;
        // filler is addi x0 with the word index as immediate
        for (int i = 0; i < mem_words; i++) begin
            program_mem[i] = {4'h0, 8'(i), 20'h00013};
        end
        fd = $fopen("sim/program_input.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open sim/program_input.txt");
        end
        done = 1'b0;
        while (!done) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                n = $fgets(rest, fd);
            end else if (kind == "I") begin
                n = $fscanf(fd, " %h %h", addr, word);
                if ((n != 2) || (addr >= 4 * mem_words)) begin
                    stop_with_failure("bad program line in sim/program_input.txt");
                end
                program_mem[addr[9:2]] = word;
            end else if (kind == "C") begin
                n = $fscanf(fd, " %d %d %h %h", rec_wr_en, rec_idx, rec_data, rec_npc);
                if (n != 4) begin
                    stop_with_failure("bad commit line in sim/program_input.txt");
                end
                entry.wr_en = rec_wr_en[0];
                entry.idx   = rec_idx[4:0];
                entry.data  = rec_data;
                entry.npc   = rec_npc;
                expected.push_back(entry);
            end else begin
                stop_with_failure("unknown record type in sim/program_input.txt");
            end
        end
        $fclose(fd);
        if (expected.size() == 0) begin
            stop_with_failure("sim/program_input.txt holds no commit records");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tagged memory with random rejects and latency
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            mem2proc_response <= '0;
            mem2proc_tag      <= '0;
            busy     = 1'b0;
            next_tag = 4'd1;
        end else begin
            rng = lcg_step(rng);
            // reply is one cycle wide
            if (busy && (wait_cnt == 2'd0)) begin
                mem2proc_tag  <= cur_tag;
                mem2proc_data <= read_block(cur_addr);
                busy = 1'b0;
            end else begin
                mem2proc_tag <= '0;
                if (busy) begin
                    wait_cnt = wait_cnt - 2'd1;
                end
            end
            // request against a nonzero offer is accepted
            if ((proc2mem_command == BUS_LOAD) && (mem2proc_response != '0)) begin
                if (!first_seen) begin
                    check_fetch_addr(proc2mem_addr);
                    first_seen = 1'b1;
                end
                busy     = 1'b1;
                cur_tag  = mem2proc_response;
                cur_addr = proc2mem_addr;
                wait_cnt = rng[29:28];
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
            end
            // roughly one offer in four is a reject
            if (!busy && (rng[31:30] != 2'b00)) begin
                mem2proc_response <= next_tag;
            end else begin
                mem2proc_response <= '0;
            end
        end
    end

    // cycle budget scales with the commit count
    always @(posedge clock) begin
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
                    cycle_limit));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        load_program();
        cycle_limit = 40 * expected.size() + 200;
        repeat (8) @(posedge clock);
        reset <= 1'b0;

        // first cycle out of reset, bus idle
        @(negedge clock);
        check_idle();
        check_status(NO_ERROR);
        check_command(BUS_NONE);

        // outputs sampled mid-cycle
        while (expected.size() > 0) begin
            @(negedge clock);
            if (commit_valid) begin
                rec = expected.pop_front();
                check_commit(rec.wr_en, rec.idx, rec.data, rec.npc);
                commits_seen++;
                if (expected.size() > 0) begin
                    check_status(NO_ERROR);
                end
            end
        end

        // halted after wfi, nothing else retires
        repeat (20) begin
            @(negedge clock);
            check_idle();
            check_status(HALTED_ON_WFI);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== sim/program_input.txt ====
# I <byte address hex> <instruction word hex>
# C <wr_en> <dest idx dec> <data hex> <next pc hex> listed in commit order
# alu chain with back-to-back dependences
I 00 00500093
I 04 00708113
I 08 002081b3
I 0c 40208233
I 10 001222b3
I 14 12345337
I 18 003343b3
I 1c 0023e433
I 20 004474b3
# beq not taken then bne taken over two wrong-path addi
I 24 00508663
I 28 00509663
I 2c 00100513
I 30 00200593
# beq taken then jal over wrong-path words
I 34 00318463
I 38 00300613
I 3c 00c006ef
I 40 00400713
I 44 00500793
# uses the jal link
I 48 fff68813
I 4c 0040a8b3
I 50 00000013
# wfi and two words that must never commit
I 54 10500073
I 58 00900913
I 5c 00900993
# expected commits
C 1 1 00000005 00000004
C 1 2 0000000c 00000008
C 1 3 00000011 0000000c
C 1 4 fffffff9 00000010
C 1 5 00000001 00000014
C 1 6 12345000 00000018
C 1 7 12345011 0000001c
C 1 8 1234501d 00000020
C 1 9 12345019 00000024
C 0 0 00000000 00000028
C 0 0 00000000 00000034
C 0 0 00000000 0000003c
C 1 13 00000040 00000048
C 1 16 0000003f 0000004c
C 1 17 00000000 00000050
C 0 0 00000000 00000054
C 0 0 00000000 00000058

// ==== compile.f ====
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/regfile.sv
logic/execute_unit.sv
logic/retire_unit.sv
logic/pipeline.sv
sim/pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_pipeline

sources:
  - files:
      - logic/pipe_pkg.sv
      - logic/fetch_unit.sv
      - logic/decode_unit.sv
      - logic/regfile.sv
      - logic/execute_unit.sv
      - logic/retire_unit.sv
      - logic/pipeline.sv
  - target: simulation
    files:
      - sim/pipeline_tb.sv
